/* bitserial_core.f */
+incdir+include
verilog/bitserial_pkg.sv
verilog/bitserial_state.sv
verilog/bitserial_decode.sv
verilog/bitserial_alu.sv
verilog/bitserial_ctrl.sv
verilog/bitserial_rf.sv
verilog/bitserial_writeback.sv
verilog/bitserial_top.sv
verification/bitserial_props.sv
verification/bitserial_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := bitserial_tb
FILELIST  := bitserial_core.f
OBJ_DIR   := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/bitserial_config.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* verification/bitserial_tb.sv */
`include "bitserial_config.svh"

module bitserial_tb
   import bitserial_pkg::*;
();

   localparam int WAIT_LIMIT = 200;
   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;
   localparam logic [6:0] F7_SUB = 7'b0100000;

   typedef struct packed {
      instr_u              instr;
      logic [`BS_XLEN-1:0] next_pc;
      logic                is_store;
      dbus_req_t           req;
   } entry_t;

   logic                clk;
   logic                i_reset;
   logic [`BS_XLEN-1:0] o_ibus_adr;
   logic                o_ibus_cyc;
   instr_u              i_ibus_rdt;
   logic                i_ibus_ack;
   dbus_req_t           o_dbus;
   logic                o_dbus_cyc;
   logic                i_dbus_ack;

   entry_t              prog[$];
   logic [`BS_XLEN-1:0] build_pc;

   bitserial_top DUT (
      .clk        (clk),
      .i_reset    (i_reset),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus     (o_dbus),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack)
   );

   bind bitserial_top bitserial_props props (
      .clk        (clk),
      .i_reset    (i_reset),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus     (o_dbus),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Instruction encoders take operands in assembler order
   function automatic instr_u r_word(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
      instr_u w;
      w.rtype = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP};
      return w;
   endfunction

   function automatic instr_u i_word(input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [4:0] rs1, input int imm);
      instr_u w;
      w.itype = '{imm: imm[11:0], rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP_IMM};
      return w;
   endfunction

   function automatic instr_u u_word(input logic [4:0] rd, input logic [19:0] imm);
      instr_u w;
      w.utype = '{imm: imm, rd: rd, opcode: OPC_LUI};
      return w;
   endfunction

   function automatic instr_u s_word(input logic [4:0] rs2, input logic [4:0] rs1, input int off);
      instr_u w;
      w.rtype = '{funct7: off[11:5], rs2: rs2, rs1: rs1, funct3: 3'b010,
                  rd: off[4:0], opcode: OPC_STORE};
      return w;
   endfunction

   // B form scatters offset bits 12, 11, 10:5 and 4:1
   function automatic instr_u b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [4:0] rs2, input int off);
      instr_u w;
      w.rtype = '{funct7: {off[12], off[10:5]}, rs2: rs2, rs1: rs1, funct3: f3,
                  rd: {off[4:1], off[11]}, opcode: OPC_BRANCH};
      return w;
   endfunction

   task automatic append(input instr_u w, input logic [`BS_XLEN-1:0] next,
                         input logic st, input dbus_req_t req);
      entry_t e;
      e.instr    = w;
      e.next_pc  = next;
      e.is_store = st;
      e.req      = req;
      prog.push_back(e);
      build_pc = next;
   endtask

   task automatic op_entry(input instr_u w);
      append(w, build_pc + 32'd4, 1'b0, '0);
   endtask

   // Store address forced to a word boundary
   task automatic store_entry(input instr_u w, input logic [`BS_XLEN-1:0] sum,
                              input logic [`BS_XLEN-1:0] dat);
      dbus_req_t req;
      req = '{adr: sum & ~32'd3, dat: dat, we: 1'b1};
      append(w, build_pc + 32'd4, 1'b1, req);
   endtask

   task automatic branch_entry(input instr_u w, input logic taken, input int off);
      if (taken) begin
         append(w, build_pc + off, 1'b0, '0);
      end else begin
         append(w, build_pc + 32'd4, 1'b0, '0);
      end
   endtask

   task automatic build_program();
      build_pc = `BS_RESET_PC;
      op_entry(i_word(F3_ADD, 5'd1, 5'd0, 12'h123));
      store_entry(s_word(5'd1, 5'd0, 12'h040), 32'h40, 32'h0000_0123);
      op_entry(u_word(5'd2, 20'h80001));
      store_entry(s_word(5'd2, 5'd0, 12'h044), 32'h44, 32'h8000_1000);
      op_entry(i_word(F3_ADD, 5'd3, 5'd0, -1));
      op_entry(i_word(F3_ADD, 5'd4, 5'd0, 1));
      // All-ones plus one wraps to zero
      op_entry(r_word(7'd0, F3_ADD, 5'd5, 5'd3, 5'd4));
      store_entry(s_word(5'd5, 5'd0, 12'h048), 32'h48, 32'h0000_0000);
      op_entry(r_word(F7_SUB, F3_ADD, 5'd6, 5'd4, 5'd3));
      store_entry(s_word(5'd6, 5'd0, 12'h04C), 32'h4C, 32'h0000_0002);
      op_entry(r_word(F7_SUB, F3_ADD, 5'd7, 5'd0, 5'd4));
      store_entry(s_word(5'd7, 5'd1, -211), 32'h123 - 32'd211, 32'hFFFF_FFFF);
      op_entry(r_word(7'd0, F3_AND, 5'd8, 5'd2, 5'd3));
      store_entry(s_word(5'd8, 5'd0, 12'h054), 32'h54, 32'h8000_1000);
      op_entry(r_word(7'd0, F3_XOR, 5'd9, 5'd2, 5'd3));
      store_entry(s_word(5'd9, 5'd0, 12'h058), 32'h58, 32'h7FFF_EFFF);
      op_entry(i_word(F3_AND, 5'd11, 5'd3, 12'h0F0));
      store_entry(s_word(5'd11, 5'd0, 12'h060), 32'h60, 32'h0000_00F0);
      // Operands share some bits so OR differs from XOR and ADD
      op_entry(r_word(7'd0, F3_OR, 5'd10, 5'd1, 5'd11));
      store_entry(s_word(5'd10, 5'd0, 12'h05C), 32'h5C, 32'h0000_01F3);
      op_entry(i_word(F3_OR, 5'd12, 5'd2, -2048));
      store_entry(s_word(5'd12, 5'd0, 12'h064), 32'h64, 32'hFFFF_F800);
      op_entry(i_word(F3_XOR, 5'd13, 5'd1, 12'h7FF));
      store_entry(s_word(5'd13, 5'd0, 12'h068), 32'h68, 32'h0000_06DC);
      // x0 stays zero after a write
      op_entry(i_word(F3_ADD, 5'd0, 5'd1, 5));
      store_entry(s_word(5'd0, 5'd0, 12'h06C), 32'h6C, 32'h0000_0000);
      branch_entry(b_word(F3_BEQ, 5'd1, 5'd1, 8), 1'b1, 8);
      branch_entry(b_word(F3_BNE, 5'd1, 5'd1, 12), 1'b0, 12);
      branch_entry(b_word(F3_BNE, 5'd3, 5'd4, -16), 1'b1, -16);
      branch_entry(b_word(F3_BEQ, 5'd3, 5'd4, -20), 1'b0, -20);
      branch_entry(b_word(F3_BEQ, 5'd0, 5'd5, 2056), 1'b1, 2056);
      branch_entry(b_word(F3_BNE, 5'd2, 5'd0, -2048), 1'b1, -2048);
      branch_entry(b_word(F3_BEQ, 5'd7, 5'd3, -112), 1'b1, -112);
      // Unaligned sum loses its low address bits
      store_entry(s_word(5'd6, 5'd1, 12'h070), 32'h123 + 32'h70, 32'h0000_0002);
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic abort_run();
      $display("Done: errors found");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_fetch(input logic [`BS_XLEN-1:0] got, input logic [`BS_XLEN-1:0] exp);
      if (got !== exp) begin
         $display("Fail time %0t o_ibus_adr got %h expected %h", $time, got, exp);
         abort_run();
      end
   endtask

   task automatic check_store(input dbus_req_t got, input dbus_req_t exp);
      if (got !== exp) begin
         $display("Fail time %0t o_dbus got adr %h dat %h we %b expected adr %h dat %h we %b",
                  $time, got.adr, got.dat, got.we, exp.adr, exp.dat, exp.we);
         abort_run();
      end
   endtask

   task automatic wait_fetch();
      int n;
      n = 0;
      while (!o_ibus_cyc && !o_dbus_cyc && n < WAIT_LIMIT) begin
         step();
         n++;
      end
      if (o_dbus_cyc) begin
         $display("A store request came where none was expected, at time %0t", $time);
         abort_run();
      end else if (!o_ibus_cyc) begin
         $display("Timed out waiting for an instruction fetch at time %0t", $time);
         abort_run();
      end
   endtask

   task automatic wait_store();
      int n;
      n = 0;
      while (!o_dbus_cyc && !o_ibus_cyc && n < WAIT_LIMIT) begin
         step();
         n++;
      end
      if (o_ibus_cyc) begin
         $display("The next fetch came before the expected store, at time %0t", $time);
         abort_run();
      end else if (!o_dbus_cyc) begin
         $display("Timed out waiting for a store request at time %0t", $time);
         abort_run();
      end
   endtask

   task automatic give_fetch(input instr_u w);
      int d;
      d = int'($urandom % 4);
      repeat (d) step();
      i_ibus_rdt = w;
      i_ibus_ack = 1'b1;
      step();
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
   endtask

   task automatic give_store_ack();
      int d;
      d = int'($urandom % 4);
      repeat (d) step();
      i_dbus_ack = 1'b1;
      step();
      i_dbus_ack = 1'b0;
   endtask

   initial begin
      entry_t              e;
      logic [`BS_XLEN-1:0] exp_pc;
      int                  seed_ret;
      i_reset    = 1'b1;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
      seed_ret   = $urandom(22);
      build_program();
      repeat (3) @(posedge clk);
      #1;
      i_reset = 1'b0;
      exp_pc  = `BS_RESET_PC;
      foreach (prog[k]) begin
         e = prog[k];
         wait_fetch();
         check_fetch(o_ibus_adr, exp_pc);
         give_fetch(e.instr);
         if (e.is_store) begin
            wait_store();
            check_store(o_dbus, e.req);
            give_store_ack();
         end
         exp_pc = e.next_pc;
      end
      wait_fetch();
      check_fetch(o_ibus_adr, exp_pc);
      $display("Done: no errors");
      $finish;
   end

endmodule

/* verification/bitserial_props.sv */
`include "bitserial_config.svh"

module bitserial_props
   import bitserial_pkg::*;
(
   input logic                clk,
   input logic                i_reset,
   input logic [`BS_XLEN-1:0] o_ibus_adr,
   input logic                o_ibus_cyc,
   input logic                i_ibus_ack,
   input dbus_req_t           o_dbus,
   input logic                o_dbus_cyc,
   input logic                i_dbus_ack
);

   // Only one bus owns a cycle at a time
   one_bus_a: assert property (@(posedge clk) disable iff (i_reset)
      !(o_ibus_cyc && o_dbus_cyc))
      else $error("ibus and dbus cycles high together");

   // Fetch address held until the ack
   ibus_hold_a: assert property (@(posedge clk) disable iff (i_reset)
      o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc && $stable(o_ibus_adr))
      else $error("ibus request changed before its ack");

   dbus_hold_a: assert property (@(posedge clk) disable iff (i_reset)
      o_dbus_cyc && !i_dbus_ack |=> o_dbus_cyc && $stable(o_dbus))
      else $error("dbus request changed before its ack");

   reset_a: assert property (@(posedge clk) i_reset |=> !o_dbus_cyc)
      else $error("dbus cycle high right after reset");

endmodule

/* verilog/bitserial_top.sv */
`include "bitserial_config.svh"

module bitserial_top
   import bitserial_pkg::*;
(
   input  logic                clk,
   input  logic                i_reset,
   output logic [`BS_XLEN-1:0] o_ibus_adr,
   output logic                o_ibus_cyc,
   input  instr_u              i_ibus_rdt,
   input  logic                i_ibus_ack,
   output dbus_req_t           o_dbus,
   output logic                o_dbus_cyc,
   input  logic                i_dbus_ack
);

   phase_e               phase;
   logic [`BS_CNT_W-1:0] cnt;
   logic                 cnt_en;
   logic                 cnt_done;
   logic                 first;
   logic                 fetch_ack;
   ctrl_t                ctrl;
   logic                 imm_bit;
   logic                 rs1_bit;
   logic                 rs2_bit;
   logic                 alu_bit;
   logic                 cmp_eq;
   logic                 rd_bit;
   logic                 rd_wen;

   assign first     = cnt_en & (cnt == '0);
   assign fetch_ack = o_ibus_cyc & i_ibus_ack;

   bitserial_state state (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_is_store (ctrl.is_store),
      .o_phase    (phase),
      .o_cnt      (cnt),
      .o_cnt_en   (cnt_en),
      .o_cnt_done (cnt_done),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc)
   );

   bitserial_decode decode (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_ibus_rdt  (i_ibus_rdt),
      .i_fetch_ack (fetch_ack),
      .i_cnt       (cnt),
      .i_cnt_en    (cnt_en),
      .o_ctrl      (ctrl),
      .o_imm_bit   (imm_bit)
   );

   // Immediate or rs2 as the second operand
   bitserial_alu alu (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_cnt_en (cnt_en),
      .i_first  (first),
      .i_rs1    (rs1_bit),
      .i_op_b   (ctrl.use_imm ? imm_bit : rs2_bit),
      .i_alu_op (ctrl.alu_op),
      .o_rd_bit (alu_bit),
      .o_cmp_eq (cmp_eq)
   );

   bitserial_ctrl ctrl_pc (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_phase    (phase),
      .i_cnt_en   (cnt_en),
      .i_first    (first),
      .i_cnt_done (cnt_done),
      .i_imm_bit  (imm_bit),
      .i_ctrl     (ctrl),
      .i_cmp_eq   (cmp_eq),
      .o_ibus_adr (o_ibus_adr)
   );

   bitserial_rf rf (
      .clk        (clk),
      .i_cnt      (cnt),
      .i_cnt_en   (cnt_en),
      .i_rs1_addr (ctrl.rs1_addr),
      .i_rs2_addr (ctrl.rs2_addr),
      .i_rd_addr  (ctrl.rd_addr),
      .i_rd_wen   (rd_wen),
      .i_rd_bit   (rd_bit),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit)
   );

   bitserial_writeback writeback (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_ctrl     (ctrl),
      .i_alu_bit  (alu_bit),
      .i_rs2_bit  (rs2_bit),
      .i_dbus_ack (i_dbus_ack),
      .o_rd_bit   (rd_bit),
      .o_rd_wen   (rd_wen),
      .o_dbus     (o_dbus)
   );

endmodule

/* verilog/bitserial_writeback.sv */
`include "bitserial_config.svh"

module bitserial_writeback
   import bitserial_pkg::*;
(
   input  logic      clk,
   input  logic      i_reset,
   input  logic      i_cnt_en,
   input  logic      i_cnt_done,
   input  ctrl_t     i_ctrl,
   input  logic      i_alu_bit,
   input  logic      i_rs2_bit,
   input  logic      i_dbus_ack,
   output logic      o_rd_bit,
   output logic      o_rd_wen,
   output dbus_req_t o_dbus
);

   logic [`BS_XLEN-1:0] adr_sr;
   logic [`BS_XLEN-1:0] dat_sr;
   logic                pending_q;
   logic                capture;

   assign o_rd_bit = i_alu_bit;
   assign o_rd_wen = i_cnt_en & i_ctrl.rd_en;

   // Store waiting for its ack
   always_ff @(posedge clk) begin
      if (i_reset) begin
         pending_q <= 1'b0;
      end else if (i_cnt_done & i_ctrl.is_store) begin
         pending_q <= 1'b1;
      end else if (i_dbus_ack) begin
         pending_q <= 1'b0;
      end
   end

   assign capture = i_cnt_en & i_ctrl.is_store & ~pending_q;

   // ALU gives rs1+imm for the address
   always_ff @(posedge clk) begin
      if (capture) begin
         adr_sr <= {i_alu_bit, adr_sr[`BS_XLEN-1:1]};
         dat_sr <= {i_rs2_bit, dat_sr[`BS_XLEN-1:1]};
      end
   end

   assign o_dbus = '{
      adr: {adr_sr[`BS_XLEN-1:2], 2'b00},
      dat: dat_sr,
      we:  1'b1
   };

endmodule

/* verilog/bitserial_rf.sv */
`include "bitserial_config.svh"

module bitserial_rf (
   input  logic                 clk,
   input  logic [`BS_CNT_W-1:0] i_cnt,
   input  logic                 i_cnt_en,
   input  logic [4:0]           i_rs1_addr,
   input  logic [4:0]           i_rs2_addr,
   input  logic [4:0]           i_rd_addr,
   input  logic                 i_rd_wen,
   input  logic                 i_rd_bit,
   output logic                 o_rs1_bit,
   output logic                 o_rs2_bit
);

   // One bit per entry, addressed by {register, bit}
   logic bits_q [32*`BS_XLEN];
   logic rd_we;
   logic rs1_q;
   logic rs2_q;

   assign rd_we = i_cnt_en & i_rd_wen & (i_rd_addr != 5'd0);

   always_ff @(posedge clk) begin
      if (rd_we) begin
         bits_q[{i_rd_addr, i_cnt}] <= i_rd_bit;
      end
   end

   // Read happens before the same bit is overwritten
   assign rs1_q = bits_q[{i_rs1_addr, i_cnt}];
   assign rs2_q = bits_q[{i_rs2_addr, i_cnt}];

   // x0 reads as zero
   assign o_rs1_bit = (i_rs1_addr != 5'd0) & rs1_q;
   assign o_rs2_bit = (i_rs2_addr != 5'd0) & rs2_q;

endmodule

/* verilog/bitserial_ctrl.sv */
`include "bitserial_config.svh"

module bitserial_ctrl
   import bitserial_pkg::*;
(
   input  logic                clk,
   input  logic                i_reset,
   input  phase_e              i_phase,
   input  logic                i_cnt_en,
   input  logic                i_first,
   input  logic                i_cnt_done,
   input  logic                i_imm_bit,
   input  ctrl_t               i_ctrl,
   input  logic                i_cmp_eq,
   output logic [`BS_XLEN-1:0] o_ibus_adr
);

   logic [`BS_XLEN-1:0] pc_q;
   logic [`BS_XLEN-1:0] seq_sr;
   logic [`BS_XLEN-1:0] tgt_sr;
   logic [1:0]          four_sr;
   logic                pc_bit;
   logic                four_bit;
   logic                seq_c_q;
   logic                seq_c_in;
   logic                seq_sum;
   logic                tgt_c_q;
   logic                tgt_c_in;
   logic                tgt_sum;
   logic                take;

   assign pc_bit = seq_sr[0];

   // Constant four, one bit per cycle
   assign four_bit = i_first ? 1'b0 : four_sr[0];

   assign seq_c_in = ~i_first & seq_c_q;
   assign seq_sum  = pc_bit ^ four_bit ^ seq_c_in;
   assign tgt_c_in = ~i_first & tgt_c_q;
   assign tgt_sum  = pc_bit ^ i_imm_bit ^ tgt_c_in;

   // Equal for BEQ, not equal for BNE
   assign take = i_ctrl.is_branch & (i_cmp_eq ^ i_ctrl.branch_ne);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc_q    <= `BS_RESET_PC;
         seq_c_q <= 1'b0;
         tgt_c_q <= 1'b0;
         four_sr <= '0;
      end else begin
         if (i_cnt_en) begin
            seq_c_q <= (pc_bit & four_bit) | (seq_c_in & (pc_bit ^ four_bit));
            tgt_c_q <= (pc_bit & i_imm_bit) | (tgt_c_in & (pc_bit ^ i_imm_bit));
            four_sr <= i_first ? 2'b10 : {1'b0, four_sr[1]};
         end
         if (i_cnt_done) begin
            pc_q <= take ? {tgt_sum, tgt_sr[`BS_XLEN-1:1]} : {seq_sum, seq_sr[`BS_XLEN-1:1]};
         end
      end
   end

   // Working copy of the PC drains out as PC+4 fills in
   always_ff @(posedge clk) begin
      if (i_phase == PH_DECODE) begin
         seq_sr <= pc_q;
      end else if (i_cnt_en) begin
         seq_sr <= {seq_sum, seq_sr[`BS_XLEN-1:1]};
      end
      if (i_cnt_en) begin
         tgt_sr <= {tgt_sum, tgt_sr[`BS_XLEN-1:1]};
      end
   end

   assign o_ibus_adr = pc_q;

endmodule

/* verilog/bitserial_alu.sv */
module bitserial_alu
   import bitserial_pkg::*;
(
   input  logic    clk,
   input  logic    i_reset,
   input  logic    i_cnt_en,
   input  logic    i_first,
   input  logic    i_rs1,
   input  logic    i_op_b,
   input  alu_op_e i_alu_op,
   output logic    o_rd_bit,
   output logic    o_cmp_eq
);

   logic is_sub;
   logic op_b_eff;
   logic carry_q;
   logic carry_in;
   logic sum;
   logic eq_q;
   logic eq_in;
   logic bit_eq;

   // Subtract as rs1 + ~op_b + 1
   assign is_sub   = (i_alu_op == ALU_SUB);
   assign op_b_eff = i_op_b ^ is_sub;
   assign carry_in = i_first ? is_sub : carry_q;
   assign sum      = i_rs1 ^ op_b_eff ^ carry_in;

   assign bit_eq = ~(i_rs1 ^ i_op_b);
   assign eq_in  = i_first | eq_q;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b1;
      end else if (i_cnt_en) begin
         carry_q <= (i_rs1 & op_b_eff) | (carry_in & (i_rs1 ^ op_b_eff));
         eq_q    <= eq_in & bit_eq;
      end
   end

   // Current bit folded in, so the last bit counts at cnt_done
   assign o_cmp_eq = eq_in & bit_eq;

   always_comb begin
      case (i_alu_op)
         ALU_ADD,
         ALU_SUB:    o_rd_bit = sum;
         ALU_AND:    o_rd_bit = i_rs1 & i_op_b;
         ALU_OR:     o_rd_bit = i_rs1 | i_op_b;
         ALU_XOR:    o_rd_bit = i_rs1 ^ i_op_b;
         ALU_PASS_B: o_rd_bit = i_op_b;
         default:    o_rd_bit = 1'b0;
      endcase
   end

endmodule

/* verilog/bitserial_decode.sv */
`include "bitserial_config.svh"

module bitserial_decode
   import bitserial_pkg::*;
(
   input  logic                 clk,
   input  logic                 i_reset,
   input  instr_u               i_ibus_rdt,
   input  logic                 i_fetch_ack,
   input  logic [`BS_CNT_W-1:0] i_cnt,
   input  logic                 i_cnt_en,
   output ctrl_t                o_ctrl,
   output logic                 o_imm_bit
);

   instr_u              instr_q;
   opcode_e             opc;
   ctrl_t               ctrl;
   logic [`BS_XLEN-1:0] imm_full;
   logic [`BS_XLEN-1:0] imm_sr;
   logic                first_bit;

   // Cleared word decodes as illegal, so nothing runs by accident
   always_ff @(posedge clk) begin
      if (i_reset) begin
         instr_q <= '0;
      end else if (i_fetch_ack) begin
         instr_q <= i_ibus_rdt;
      end
   end

   assign opc = opcode_e'(instr_q.rtype.opcode);

   always_comb begin
      ctrl          = '0;
      ctrl.rd_addr  = instr_q.rtype.rd;
      ctrl.rs1_addr = instr_q.rtype.rs1;
      ctrl.rs2_addr = instr_q.rtype.rs2;
      ctrl.alu_op   = ALU_ADD;
      imm_full      = '0;
      case (opc)
         OPC_OP, OPC_OP_IMM: begin
            ctrl.rd_en   = 1'b1;
            ctrl.use_imm = (opc == OPC_OP_IMM);
            imm_full     = {{20{instr_q.itype.imm[11]}}, instr_q.itype.imm};
            case (instr_q.rtype.funct3)
               3'b000: begin
                  // SUB only exists in the register form
                  if (opc == OPC_OP && instr_q.rtype.funct7 == 7'b0100000) begin
                     ctrl.alu_op = ALU_SUB;
                  end
               end
               3'b100: ctrl.alu_op = ALU_XOR;
               3'b110: ctrl.alu_op = ALU_OR;
               3'b111: ctrl.alu_op = ALU_AND;
               default: ctrl.illegal = 1'b1;
            endcase
            if (opc == OPC_OP && instr_q.rtype.funct7 != 7'b0000000 && ctrl.alu_op != ALU_SUB) begin
               ctrl.illegal = 1'b1;
            end
         end
         OPC_LUI: begin
            ctrl.rd_en   = 1'b1;
            ctrl.use_imm = 1'b1;
            ctrl.alu_op  = ALU_PASS_B;
            imm_full     = {instr_q.utype.imm, 12'b0};
         end
         OPC_BRANCH: begin
            ctrl.is_branch = 1'b1;
            ctrl.branch_ne = instr_q.rtype.funct3[0];
            ctrl.alu_op    = ALU_SUB;
            ctrl.illegal   = (instr_q.rtype.funct3[2:1] != 2'b00);
            imm_full = {{19{instr_q.rtype.funct7[6]}}, instr_q.rtype.funct7[6],
                        instr_q.rtype.rd[0], instr_q.rtype.funct7[5:0],
                        instr_q.rtype.rd[4:1], 1'b0};
         end
         OPC_STORE: begin
            ctrl.is_store = 1'b1;
            ctrl.use_imm  = 1'b1;
            ctrl.illegal  = (instr_q.rtype.funct3 != 3'b010);
            imm_full = {{20{instr_q.rtype.funct7[6]}}, instr_q.rtype.funct7, instr_q.rtype.rd};
         end
         default: ctrl.illegal = 1'b1;
      endcase
      if (ctrl.illegal) begin
         ctrl.rd_en     = 1'b0;
         ctrl.is_store  = 1'b0;
         ctrl.is_branch = 1'b0;
      end
   end

   // Bit 0 comes straight from the word, the register supplies the rest
   assign first_bit = (i_cnt == '0);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         if (first_bit) begin
            imm_sr <= {imm_full[`BS_XLEN-1], imm_full[`BS_XLEN-1:1]};
         end else begin
            imm_sr <= {imm_sr[`BS_XLEN-1], imm_sr[`BS_XLEN-1:1]};
         end
      end
   end

   assign o_imm_bit = first_bit ? imm_full[0] : imm_sr[0];
   assign o_ctrl    = ctrl;

endmodule

/* verilog/bitserial_state.sv */
`include "bitserial_config.svh"

module bitserial_state
   import bitserial_pkg::*;
(
   input  logic                 clk,
   input  logic                 i_reset,
   input  logic                 i_ibus_ack,
   input  logic                 i_dbus_ack,
   input  logic                 i_is_store,
   output phase_e               o_phase,
   output logic [`BS_CNT_W-1:0] o_cnt,
   output logic                 o_cnt_en,
   output logic                 o_cnt_done,
   output logic                 o_ibus_cyc,
   output logic                 o_dbus_cyc
);

   phase_e               phase_q;
   logic [`BS_CNT_W-1:0] cnt_q;
   logic                 last_bit;

   assign last_bit = (cnt_q == {`BS_CNT_W{1'b1}});

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase_q <= PH_FETCH;
         cnt_q   <= '0;
      end else begin
         case (phase_q)
            PH_FETCH: begin
               if (i_ibus_ack) begin
                  phase_q <= PH_DECODE;
               end
            end
            PH_DECODE: begin
               phase_q <= PH_EXEC;
            end
            PH_EXEC: begin
               // Counter wraps back to zero on its own
               cnt_q <= cnt_q + 1'b1;
               if (last_bit) begin
                  phase_q <= i_is_store ? PH_STORE : PH_FETCH;
               end
            end
            PH_STORE: begin
               if (i_dbus_ack) begin
                  phase_q <= PH_FETCH;
               end
            end
            default: phase_q <= PH_FETCH;
         endcase
      end
   end

   assign o_phase    = phase_q;
   assign o_cnt      = cnt_q;
   assign o_cnt_en   = (phase_q == PH_EXEC);
   assign o_cnt_done = o_cnt_en & last_bit;
   assign o_ibus_cyc = (phase_q == PH_FETCH);
   assign o_dbus_cyc = (phase_q == PH_STORE);

endmodule

/* verilog/bitserial_pkg.sv */
`include "bitserial_config.svh"

package bitserial_pkg;

   // Three field layouts over one instruction word
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_view_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_view_t;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_view_t;

   typedef union packed {
      r_view_t rtype;
      i_view_t itype;
      u_view_t utype;
   } instr_u;

   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_BRANCH = 7'b1100011,
      OPC_STORE  = 7'b0100011
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
   } alu_op_e;

   typedef struct packed {
      logic [4:0] rd_addr;
      logic [4:0] rs1_addr;
      logic [4:0] rs2_addr;
      alu_op_e    alu_op;
      logic       use_imm;
      logic       rd_en;
      logic       is_branch;
      logic       branch_ne;
      logic       is_store;
      logic       illegal;
   } ctrl_t;

   typedef enum logic [1:0] {PH_FETCH, PH_DECODE, PH_EXEC, PH_STORE} phase_e;

   typedef struct packed {
      logic [`BS_XLEN-1:0] adr;
      logic [`BS_XLEN-1:0] dat;
      logic                we;
   } dbus_req_t;

endpackage

/* include/bitserial_config.svh */
`ifndef BITSERIAL_CONFIG_SVH
`define BITSERIAL_CONFIG_SVH

// Data path width and bit counter width
`define BS_XLEN 32
`define BS_CNT_W 5

// First fetch address out of reset
`define BS_RESET_PC 32'h0000_0000

`endif
